/* flist.f */
design/cin_pkg.sv
design/cin_bit_align.sv
design/cin_parallel_sync.sv
design/cin_link_regs.sv
design/cin_link_top.sv
test/cin_link_assert.sv
test/tb_cin_link.sv

/* Bender.yml */
package:
  name: cin_link

sources:
  - files:
      - design/cin_pkg.sv
      - design/cin_bit_align.sv
      - design/cin_parallel_sync.sv
      - design/cin_link_regs.sv
      - design/cin_link_top.sv
  - target: test
    files:
      - test/cin_link_assert.sv
      - test/tb_cin_link.sv

/* test/tb_cin_link.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cin_link import cin_pkg::*; ();

    localparam cin_word_t TRAIN      = 32'hA55A6996;
    // bit offset of the stream model against the nibble grid
    localparam int        K_OFFSET   = 2;
    localparam int        MAX_CYCLES = 4000;

    logic      ifclk;
    logic      rst_lock;
    logic      ifclk_phase;
    nibble_t   cin;
    logic      req;
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
    logic      ack;
    reg_data_t rdata;
    logic      locked;
    cin_word_t cin_par;
    logic      cin_valid;

    // rising edges since start
    int unsigned cyc;
    // stream model state
    cin_word_t cur_word;
    nibble_t   s_cur;
    nibble_t   s_prev;
    // grid nibbles sent in each cycle
    nibble_t   hist [32];
    bit        random_mode;
    bit        corrupt_req;
    integer    seed;

    // scoreboard
    int          errors;
    int          checks;
    int          valid_cnt;
    int          assert_fails;
    roundtrip_t  model_phase;
    roundtrip_t  valid_phase;
    bit          ph_d1;
    bit          ph_d2;
    int unsigned req_cyc;
    string       test_name;

    cin_link_top #(
        .TRAIN_SEQUENCE (TRAIN)
    ) dut_i (
        .ifclk_i              (ifclk),
        .rst_lock_i           (rst_lock),
        .ifclk_phase_i        (ifclk_phase),
        .cin_i                (cin),
        .req_i                (req),
        .we_i                 (we),
        .addr_i               (addr),
        .wdata_i              (wdata),
        .ack_o                (ack),
        .rdata_o              (rdata),
        .locked_o             (locked),
        .cin_parallel_o       (cin_par),
        .cin_parallel_valid_o (cin_valid)
    );

    initial begin
        ifclk = 1'b0;
        forever #10 ifclk = ~ifclk;
    end

    always @(posedge ifclk) cyc <= cyc + 1;

    // phase pulse every 8 clocks
    // words start 3 clocks off the phase grid
    always @(posedge ifclk) begin
        #2;
        ifclk_phase = (cyc % 8 == 0);
        if ((cyc + 3) % 8 == 0) begin
            cur_word = random_mode ? cin_word_t'($random(seed)) : TRAIN;
        end
        s_prev = s_cur;
        s_cur  = cur_word[4 * ((cyc + 3) % 8) +: 4];
        if (corrupt_req) begin
            s_cur       = ~s_cur;
            corrupt_req = 1'b0;
        end
        hist[cyc % 32] = s_cur;
        // bit stream delayed by K_OFFSET bits
        cin = nibble_t'({s_cur, s_prev} >> (4 - K_OFFSET));
    end

    // 32-bit window whose newest grid nibble was sent in cycle newest
    function automatic cin_word_t window_at(input int unsigned newest);
        cin_word_t w;
        for (int i = 0; i < 8; i++) begin
            w[4*i +: 4] = hist[(newest - 7 + i) % 32];
        end
        return w;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // phase is 2 two clocks after a pulse and counts up from there
    // a valid word lags by the aligner and the capture clock
    // one more nibble when the aligner slips
    always @(negedge ifclk) begin
        if (ph_d2) begin
            model_phase = 3'd2;
        end else begin
            model_phase = model_phase + 3'd1;
        end
        ph_d2 = ph_d1;
        ph_d1 = ifclk_phase;
        if (cin_valid) begin
            valid_cnt++;
            valid_phase = model_phase;
            check_val("valid word", window_at(cyc - 2 - (K_OFFSET != 0)), cin_par);
        end
    end

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < 16) begin
            @(posedge ifclk);
            #2;
            n++;
        end
        if (ack !== level) begin
            errors++;
            $display("%s: ack_o stuck, did not reach %0d", test_name, level);
        end
    endtask

    // four-phase access
    // read data is taken while ack is high
    task automatic reg_access(input logic wr, input reg_addr_t a, input reg_data_t d,
                              output reg_data_t q);
        @(posedge ifclk);
        #2;
        req_cyc = cyc;
        we      = wr;
        addr    = a;
        wdata   = d;
        req     = 1'b1;
        @(posedge ifclk);
        #2;
        wait_ack(1'b1);
        q   = rdata;
        req = 1'b0;
        @(posedge ifclk);
        #2;
        wait_ack(1'b0);
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        reg_data_t unused;
        reg_access(1'b1, a, d, unused);
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_data_t q);
        reg_access(1'b0, a, 8'h00, q);
    endtask

    task automatic wait_valids(input int n);
        int target;
        int guard;
        target = valid_cnt + n;
        guard  = 0;
        while (valid_cnt < target && guard < 8 * n + 16) begin
            @(posedge ifclk);
            #2;
            guard++;
        end
        if (valid_cnt < target) begin
            errors++;
            $display("%s: valid words stopped arriving", test_name);
        end
    endtask

    initial begin
        reg_data_t q;
        int        n_bad;
        seed        = 32'h70c1;
        cyc         = 0;
        rst_lock    = 1'b1;
        ifclk_phase = 1'b0;
        cin         = '0;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        cur_word    = TRAIN;
        s_cur       = '0;
        s_prev      = '0;
        random_mode = 1'b0;
        corrupt_req = 1'b0;
        errors      = 0;
        checks      = 0;
        valid_cnt   = 0;
        model_phase = '0;
        ph_d1       = 1'b0;
        ph_d2       = 1'b0;
        test_name   = "reset";
        repeat (8) @(posedge ifclk);
        #2 rst_lock = 1'b0;

        test_name = "reset_status";
        read_reg(REG_STATUS, q);
        check_val("status", 0, q);
        read_reg(REG_ERRCNT, q);
        check_val("errcnt", 0, q);

        // slips disturb the stream, so let the error detector settle
        test_name = "slip_align";
        repeat ((4 - K_OFFSET) % 4) write_reg(REG_CTRL, 8'(1 << CTRL_SLIP_BIT));
        repeat (32) @(posedge ifclk);

        test_name = "biterr_unlocked";
        write_reg(REG_ERRCNT, 8'h00);
        read_reg(REG_STATUS, q);
        read_reg(REG_STATUS, q);
        check_val("sticky before", 0, q[4]);
        @(negedge ifclk) corrupt_req = 1'b1;
        repeat (20) @(posedge ifclk);
        read_reg(REG_STATUS, q);
        check_val("sticky", 1, q[4]);
        read_reg(REG_ERRCNT, q);
        checks++;
        if (q == 0 || q > 2) begin
            errors++;
            $display("ERROR %s: errcnt expected 1 to 2 actual %0d", test_name, q);
        end
        write_reg(REG_ERRCNT, 8'h00);
        read_reg(REG_ERRCNT, q);
        check_val("errcnt cleared", 0, q);

        // capture pulse one clock after the access
        // the word is visible one clock later
        test_name = "forced_capture";
        write_reg(REG_CTRL, 8'(1 << CTRL_CAPTURE_BIT));
        check_val("window", window_at(req_cyc - (K_OFFSET != 0)), cin_par);

        test_name = "wrong_slip";
        write_reg(REG_CTRL, 8'(1 << CTRL_SLIP_BIT));
        write_reg(REG_CTRL, 8'(1 << CTRL_LOCK_BIT));
        n_bad = 0;
        repeat (64) begin
            @(posedge ifclk);
            #2;
            if (locked) n_bad++;
        end
        check_val("locked cycles", 0, n_bad);

        // lock enable is still set, so the right offset locks at once
        test_name = "bitslip_lock";
        write_reg(REG_CTRL, 8'(1 << CTRL_RST_SLIP_BIT));
        repeat ((4 - K_OFFSET) % 4) write_reg(REG_CTRL, 8'(1 << CTRL_SLIP_BIT));
        n_bad = 0;
        while (!locked && n_bad < 64) begin
            @(posedge ifclk);
            #2;
            n_bad++;
        end
        if (!locked) begin
            errors++;
            $display("%s: locked_o never rose", test_name);
        end
        read_reg(REG_STATUS, q);
        check_val("locked bit", 1, q[0]);

        test_name = "framing_train";
        wait_valids(4);

        test_name = "roundtrip";
        read_reg(REG_STATUS, q);
        check_val("roundtrip", valid_phase, q[3:1]);

        test_name = "framing_random";
        @(negedge ifclk) random_mode = 1'b1;
        wait_valids(6);

        // count starts from zero, a locked link adds nothing
        test_name = "biterr_locked";
        write_reg(REG_ERRCNT, 8'h00);
        @(negedge ifclk) corrupt_req = 1'b1;
        repeat (20) @(posedge ifclk);
        read_reg(REG_ERRCNT, q);
        check_val("errcnt", 0, q);

        test_name = "lock_reset";
        @(posedge ifclk);
        #2 rst_lock = 1'b1;
        @(posedge ifclk);
        #2;
        check_val("locked", 0, locked);
        check_val("valid", 0, cin_valid);
        repeat (7) @(posedge ifclk);
        #2 rst_lock = 1'b0;
        n_bad = 0;
        repeat (24) begin
            @(posedge ifclk);
            #2;
            if (locked || cin_valid) n_bad++;
        end
        check_val("locked or valid cycles", 0, n_bad);

        assert_fails = dut_i.u_assert.fail_cnt;
        $display("errors: %0d  assertion failures: %0d  checks: %0d",
                 errors, assert_fails, checks);
        if (errors == 0 && assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (cyc >= MAX_CYCLES);
        $display("timeout: run still going after %0d cycles", MAX_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/cin_link_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module cin_link_assert (
    input wire ifclk_i,
    input wire rst_lock_i,
    input wire req_i,
    input wire ack_o,
    input wire locked_o,
    input wire cin_parallel_valid_o
);

    // number of failed assertions
    int fail_cnt = 0;

    // every request is answered within a few clocks
    req_gets_ack: assert property (@(posedge ifclk_i) disable iff (rst_lock_i)
        $rose(req_i) |-> ##[1:3] ack_o)
    else begin
        fail_cnt++;
        $error("req_i rise without ack_o");
    end

    // ack falls only once req is gone
    ack_falls_late: assert property (@(posedge ifclk_i) disable iff (rst_lock_i)
        $fell(ack_o) |-> $past(!req_i))
    else begin
        fail_cnt++;
        $error("ack_o fell before req_i");
    end

    // no ack out of nowhere
    ack_needs_req: assert property (@(posedge ifclk_i) disable iff (rst_lock_i)
        $rose(ack_o) |-> $past(req_i))
    else begin
        fail_cnt++;
        $error("ack_o rose without req_i");
    end

    // first word 8 clocks after lock
    first_valid: assert property (@(posedge ifclk_i) disable iff (rst_lock_i)
        $rose(locked_o) |-> !cin_parallel_valid_o [*8] ##1 cin_parallel_valid_o)
    else begin
        fail_cnt++;
        $error("first valid not 8 clocks after lock");
    end

    // then one word every 8 clocks
    valid_spacing: assert property (@(posedge ifclk_i) disable iff (rst_lock_i)
        cin_parallel_valid_o |=> !cin_parallel_valid_o [*7] ##1 cin_parallel_valid_o)
    else begin
        fail_cnt++;
        $error("valid spacing is not 8 clocks");
    end

    valid_when_locked: assert property (@(posedge ifclk_i) disable iff (rst_lock_i)
        cin_parallel_valid_o |-> locked_o)
    else begin
        fail_cnt++;
        $error("valid while unlocked");
    end

endmodule

bind cin_link_top cin_link_assert u_assert (
    .ifclk_i              (ifclk_i),
    .rst_lock_i           (rst_lock_i),
    .req_i                (req_i),
    .ack_o                (ack_o),
    .locked_o             (locked_o),
    .cin_parallel_valid_o (cin_parallel_valid_o)
);

`default_nettype wire

/* design/cin_link_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cin_link_top import cin_pkg::*; #(
    parameter cin_word_t TRAIN_SEQUENCE = 32'hA55A6996
) (
    input  wire            ifclk_i,
    input  wire            rst_lock_i,
    input  wire            ifclk_phase_i,
    input  wire nibble_t   cin_i,
    // register bus
    input  wire            req_i,
    input  wire            we_i,
    input  wire reg_addr_t addr_i,
    input  wire reg_data_t wdata_i,
    output logic           ack_o,
    output reg_data_t      rdata_o,
    // data path
    output logic           locked_o,
    output cin_word_t      cin_parallel_o,
    output logic           cin_parallel_valid_o
);

    // commands from the register block
    logic lock_cmd;
    logic bitslip_cmd;
    logic capture_cmd;
    logic rst_bitslip_cmd;
    // global reset also clears the slip offset
    logic align_rst;

    nibble_t cin_align;
    roundtrip_t roundtrip;
    logic biterr;

    assign align_rst = rst_lock_i || rst_bitslip_cmd;

    cin_link_regs u_regs (
        .ifclk_i       (ifclk_i),
        .rst_lock_i    (rst_lock_i),
        .req_i         (req_i),
        .we_i          (we_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .locked_i      (locked_o),
        .roundtrip_i   (roundtrip),
        .biterr_i      (biterr),
        .ack_o         (ack_o),
        .rdata_o       (rdata_o),
        .lock_o        (lock_cmd),
        .bitslip_o     (bitslip_cmd),
        .capture_o     (capture_cmd),
        .rst_bitslip_o (rst_bitslip_cmd)
    );

    cin_bit_align u_align (
        .ifclk_i       (ifclk_i),
        .rst_bitslip_i (align_rst),
        .bitslip_i     (bitslip_cmd),
        .cin_i         (cin_i),
        .cin_align_o   (cin_align)
    );

    cin_parallel_sync #(
        .TRAIN_SEQUENCE (TRAIN_SEQUENCE)
    ) u_sync (
        .ifclk_i              (ifclk_i),
        .rst_lock_i           (rst_lock_i),
        .ifclk_phase_i        (ifclk_phase_i),
        .cin_align_i          (cin_align),
        .lock_i               (lock_cmd),
        .capture_i            (capture_cmd),
        .locked_o             (locked_o),
        .cin_parallel_o       (cin_parallel_o),
        .cin_parallel_valid_o (cin_parallel_valid_o),
        .roundtrip_o          (roundtrip),
        .biterr_o             (biterr)
    );

endmodule

`default_nettype wire

/* design/cin_link_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cin_link_regs import cin_pkg::*; (
    input  wire            ifclk_i,
    input  wire            rst_lock_i,
    // four-phase register bus
    input  wire            req_i,
    input  wire            we_i,
    input  wire reg_addr_t addr_i,
    input  wire reg_data_t wdata_i,
    // status from the link logic
    input  wire            locked_i,
    input  wire roundtrip_t roundtrip_i,
    input  wire            biterr_i,
    output logic           ack_o,
    output reg_data_t      rdata_o,
    // one-cycle command pulses
    output logic           lock_o,
    output logic           bitslip_o,
    output logic           capture_o,
    output logic           rst_bitslip_o
);

    regs_state_t state;

    // a new request seen in idle, the access happens in this cycle
    logic access;
    logic wr_ctrl;
    logic rd_status;
    logic wr_errcnt;

    // set by any bit error, cleared by a status read
    logic biterr_sticky;
    // saturating count of bit-error cycles
    reg_data_t errcnt;
    reg_data_t status_word;

    assign access    = (state == RS_IDLE) && req_i;
    assign wr_ctrl   = access && we_i && (addr_i == REG_CTRL);
    assign rd_status = access && !we_i && (addr_i == REG_STATUS);
    assign wr_errcnt = access && we_i && (addr_i == REG_ERRCNT);

    // bit 0 locked, bits 3:1 roundtrip, bit 4 sticky bit error
    assign status_word = {3'b000, biterr_sticky, roundtrip_i, locked_i};

    // idle -> ack on req, ack -> drop when req falls, drop -> idle
    // the drop state keeps a turnaround cycle before the next access
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            state <= RS_IDLE;
        end else begin
            case (state)
                RS_IDLE: if (req_i) state <= RS_ACK;
                RS_ACK:  if (!req_i) state <= RS_DROP;
                RS_DROP: state <= RS_IDLE;
                default: state <= RS_IDLE;
            endcase
        end
    end

    // ack comes up the cycle after the access and falls the cycle after req drops
    assign ack_o = (state == RS_ACK);

    // read data is sampled during the access and held through ack
    always_ff @(posedge ifclk_i) begin
        if (access && !we_i) begin
            case (addr_i)
                REG_STATUS: rdata_o <= status_word;
                REG_ERRCNT: rdata_o <= errcnt;
                default:    rdata_o <= '0;
            endcase
        end
    end

    // each set bit of a control write fires its pulse for one clock
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            lock_o        <= 1'b0;
            bitslip_o     <= 1'b0;
            capture_o     <= 1'b0;
            rst_bitslip_o <= 1'b0;
        end else begin
            lock_o        <= wr_ctrl && wdata_i[CTRL_LOCK_BIT];
            bitslip_o     <= wr_ctrl && wdata_i[CTRL_SLIP_BIT];
            capture_o     <= wr_ctrl && wdata_i[CTRL_CAPTURE_BIT];
            rst_bitslip_o <= wr_ctrl && wdata_i[CTRL_RST_SLIP_BIT];
        end
    end

    // an error in the reading cycle survives the clear
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            biterr_sticky <= 1'b0;
        end else begin
            biterr_sticky <= biterr_i || (biterr_sticky && !rd_status);
        end
    end

    // any write to the count register clears it
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            errcnt <= '0;
        end else if (wr_errcnt) begin
            errcnt <= '0;
        end else if (biterr_i && (errcnt != 8'hFF)) begin
            errcnt <= errcnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* design/cin_parallel_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module cin_parallel_sync import cin_pkg::*; #(
    // word that the far end sends while training
    parameter cin_word_t TRAIN_SEQUENCE = 32'hA55A6996
) (
    input  wire          ifclk_i,
    input  wire          rst_lock_i,
    // one-clock pulse marking cycle 0 of the 8-clock frame
    input  wire          ifclk_phase_i,
    input  wire nibble_t cin_align_i,
    // arm the lock on the next training word
    input  wire          lock_i,
    // capture the window now, locked or not
    input  wire          capture_i,
    output logic         locked_o,
    output cin_word_t    cin_parallel_o,
    output logic         cin_parallel_valid_o,
    output roundtrip_t   roundtrip_o,
    output logic         biterr_o
);

    // seven older nibbles, oldest in bits 3:0
    logic [27:0] cin_history;
    // full 32-bit window including the newest nibble
    cin_word_t current_cin;

    logic enable_lock;
    logic locked;
    // bit 3 marks the valid cycle, bits 2:0 count within the word
    logic [3:0] ifclk_sequence;
    logic enable_capture;
    logic do_capture;

    // registered copy of the phase marker
    logic phase_buf;
    roundtrip_t phase_cnt;

    // 8-deep nibble delay for the bit-error compare
    nibble_t cin_delay [8];
    nibble_t cin_delayed;
    // counts up once after reset until the history and delay line hold real data
    logic [3:0] fill_cnt;
    logic primed;

    assign current_cin = {cin_align_i, cin_history};
    assign do_capture  = enable_capture || capture_i;
    assign cin_delayed = cin_delay[7];
    assign primed      = (fill_cnt == 4'hF);

    // shift registers, payload only
    always_ff @(posedge ifclk_i) begin
        cin_history  <= {cin_align_i, cin_history[27:4]};
        cin_delay[0] <= cin_history[3:0];
        for (int i = 1; i < 8; i++) begin
            cin_delay[i] <= cin_delay[i-1];
        end
    end

    // phase marker high -> phase 0, buffered copy high -> phase 1,
    // so the counter is reloaded with 2
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            phase_buf   <= 1'b0;
            phase_cnt   <= '0;
            roundtrip_o <= '0;
        end else begin
            phase_buf <= ifclk_phase_i;
            if (phase_buf) begin
                phase_cnt <= 3'd2;
            end else begin
                phase_cnt <= phase_cnt + 3'd1;
            end
            // delay is the phase seen when the aligned word comes out
            if (ifclk_sequence[3]) begin
                roundtrip_o <= phase_cnt;
            end
        end
    end

    // lock enable stays set until the global reset
    // locked rises one clock after the window matches the training word
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            enable_lock <= 1'b0;
            locked      <= 1'b0;
        end else begin
            if (lock_i) begin
                enable_lock <= 1'b1;
            end
            if (enable_lock && (current_cin == TRAIN_SEQUENCE)) begin
                locked <= 1'b1;
            end
        end
    end

    // sequence runs 0..8 after lock, then 1..8 so valid repeats every 8 clocks
    // capture is armed at count 6 and lands together with valid at 8
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            ifclk_sequence <= '0;
            enable_capture <= 1'b0;
        end else begin
            if (!locked) begin
                ifclk_sequence <= '0;
            end else begin
                ifclk_sequence <= {1'b0, ifclk_sequence[2:0]} + 4'd1;
            end
            enable_capture <= (ifclk_sequence == 4'h6);
        end
    end

    // word register, no reset
    always_ff @(posedge ifclk_i) begin
        if (do_capture) begin
            cin_parallel_o <= current_cin;
        end
    end

    // unlocked training repeats every 8 nibbles, any difference is a bit error
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            fill_cnt <= '0;
            biterr_o <= 1'b0;
        end else begin
            if (!primed) begin
                fill_cnt <= fill_cnt + 4'd1;
            end
            // held low while locked, and while the delay line still fills
            biterr_o <= !locked && primed && (cin_history[3:0] != cin_delayed);
        end
    end

    assign locked_o             = locked;
    assign cin_parallel_valid_o = ifclk_sequence[3];

endmodule

`default_nettype wire

/* design/cin_bit_align.sv */
`timescale 1ns/1ns
`default_nettype none

module cin_bit_align import cin_pkg::*; (
    input  wire          ifclk_i,
    // returns the offset to zero
    input  wire          rst_bitslip_i,
    // advance the window by one bit
    input  wire          bitslip_i,
    // raw nibble from the deserializer
    input  wire nibble_t cin_i,
    // aligned nibble, one clock behind cin_i
    output nibble_t      cin_align_o
);

    // previous nibble, the older half of the window
    nibble_t cin_prev;
    // current bit offset
    slip_t offset;
    // current nibble on top, previous below
    logic [7:0] cin_cat;
    // lowest bit of the selected window
    logic [2:0] win_base;

    assign cin_cat = {cin_i, cin_prev};

    // offset 0 picks the current nibble as is
    // each slip moves the window one bit further into the past
    assign win_base = 3'd4 - {1'b0, offset};

    // offset wraps 3 -> 0 by natural overflow
    always_ff @(posedge ifclk_i) begin
        if (rst_bitslip_i) begin
            offset <= '0;
        end else if (bitslip_i) begin
            offset <= offset + 2'd1;
        end
    end

    // payload path, no reset
    always_ff @(posedge ifclk_i) begin
        cin_prev    <= cin_i;
        cin_align_o <= cin_cat[win_base +: 4];
    end

endmodule

`default_nettype wire

/* design/cin_pkg.sv */
`default_nettype none

package cin_pkg;

    // one clock's worth of link input
    typedef logic [3:0] nibble_t;

    // assembled command word, oldest nibble in the low bits
    typedef logic [31:0] cin_word_t;

    // training return delay, modulo 8
    typedef logic [2:0] roundtrip_t;

    // bit offset applied by the aligner
    typedef logic [1:0] slip_t;

    // register bus
    typedef logic [1:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // register map
    localparam reg_addr_t REG_CTRL   = 2'd0;
    localparam reg_addr_t REG_STATUS = 2'd1;
    localparam reg_addr_t REG_ERRCNT = 2'd2;

    // bit positions in a control write, each one fires a command pulse
    localparam int unsigned CTRL_LOCK_BIT     = 0;
    localparam int unsigned CTRL_SLIP_BIT     = 1;
    localparam int unsigned CTRL_CAPTURE_BIT  = 2;
    localparam int unsigned CTRL_RST_SLIP_BIT = 3;

    // four-phase handshake states of the register block
    typedef enum logic [1:0] {
        RS_IDLE = 2'd0,
        RS_ACK  = 2'd1,
        RS_DROP = 2'd2
    } regs_state_t;

endpackage

`default_nettype wire
